// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - src/rv_pkg.sv
      - src/register_file.sv
      - src/fetch_stage.sv
      - src/alu.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/memory_stage.sv
      - src/rv_core.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/rv_core_tb.sv

// ==== src/alu.sv ====
`default_nettype none
`timescale 1ns/10ps

module alu (
    input  wire rv_pkg::alu_op_e op,
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    output rv_pkg::word_t        result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only low five bits shift

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module decode_stage (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                stall,
    input  wire                flush,
    input  wire rv_pkg::ifid_t ifid,
    input  wire rv_pkg::wb_t   wb,
    output rv_pkg::idex_t      idex
);
    import rv_pkg::*;

    instr_t ins;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  imm_i;
    word_t  imm_s;
    word_t  imm_b;
    idex_t  dec;

    // Shared funct3 decode for OP and OP-IMM
    function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic sub_bit, logic sra_bit);
        case (f3)
            3'b000:  return sub_bit ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sra_bit ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign ins = ifid.instr;

    register_file register_file_i (
        .clk      (clk),
        .rs1      (ins.r_fmt.rs1),
        .rs2      (ins.r_fmt.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign imm_i = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
    assign imm_s = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
    assign imm_b = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                    ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};

    always_comb begin
        dec          = '0;
        dec.pc       = ifid.pc;
        dec.rs1      = ins.r_fmt.rs1;
        dec.rs2      = ins.r_fmt.rs2;
        dec.rd       = ins.r_fmt.rd;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        case (ins.r_fmt.opcode)
            opc_op: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_from_funct3(ins.r_fmt.funct3, ins.r_fmt.funct7[5],
                                                ins.r_fmt.funct7[5]);
            end
            opc_op_imm: begin
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.alu_op      = alu_from_funct3(ins.r_fmt.funct3, 1'b0, ins.r_fmt.funct7[5]);
                // Shift amount only for slli/srli/srai
                if (ins.r_fmt.funct3[1:0] == 2'b01) dec.imm = {27'b0, ins.r_fmt.rs2};
                else                                dec.imm = imm_i;
            end
            opc_store: begin
                dec.alu_src_imm = 1'b1;
                dec.imm         = imm_s;
                dec.mem_write   = 1'b1;
                case (ins.s_fmt.funct3)
                    3'b000:  dec.mem_width = width_byte;
                    3'b001:  dec.mem_width = width_half;
                    3'b010:  dec.mem_width = width_word;
                    default: dec.mem_write = 1'b0;
                endcase
            end
            opc_branch: begin
                dec.alu_op = alu_sub; // Compare by difference
                dec.imm    = imm_b;
                if (ins.b_fmt.funct3 == 3'b000)      dec.branch_op = br_beq;
                else if (ins.b_fmt.funct3 == 3'b001) dec.branch_op = br_bne;
            end
            default: dec = '0; // Unknown opcode becomes a bubble
        endcase
    end

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idex <= '0;
        end else if (stall) begin
            // Catch a writeback retiring under a frozen entry
            if (wb.reg_write && wb.rd != '0 && wb.rd == idex.rs1) idex.rs1_data <= wb.data;
            if (wb.reg_write && wb.rd != '0 && wb.rd == idex.rs2) idex.rs2_data <= wb.data;
        end else if (flush) begin
            idex <= '0;
        end else begin
            idex <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module execute_stage (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                stall,
    input  wire rv_pkg::idex_t idex,
    input  wire rv_pkg::wb_t   wb,
    output rv_pkg::exmem_t     exmem,
    output logic               branch_taken,
    output rv_pkg::word_t      branch_target
);
    import rv_pkg::*;

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_result;
    logic  taken_next;

    // Youngest producer first
    function automatic word_t fwd_value(reg_addr_t rs, word_t reg_val, exmem_t em, wb_t w);
        if (em.reg_write && em.rd != '0 && em.rd == rs) return em.alu_out;
        if (w.reg_write && w.rd != '0 && w.rd == rs)    return w.data;
        return reg_val;
    endfunction

    assign op_a    = fwd_value(idex.rs1, idex.rs1_data, exmem, wb);
    assign rs2_fwd = fwd_value(idex.rs2, idex.rs2_data, exmem, wb); // Also the store data
    assign op_b    = idex.alu_src_imm ? idex.imm : rs2_fwd;

    alu alu_i (
        .op     (idex.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    assign taken_next = (idex.branch_op == br_beq && alu_result == '0) ||
                        (idex.branch_op == br_bne && alu_result != '0);

    // EX/MEM register and branch decision
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exmem         <= '0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
        end else if (!stall) begin
            if (branch_taken) begin
                exmem        <= '0; // Wrong-path instruction dropped
                branch_taken <= 1'b0;
            end else begin
                exmem.alu_out    <= alu_result;
                exmem.store_data <= rs2_fwd;
                exmem.rd         <= idex.rd;
                exmem.reg_write  <= idex.reg_write;
                exmem.mem_write  <= idex.mem_write;
                exmem.mem_width  <= idex.mem_width;
                branch_taken     <= taken_next;
                branch_target    <= idex.pc + idex.imm;
            end
        end
    end

    a_branch_no_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(branch_taken && exmem.reg_write))
        else $error("Taken branch sits in EX/MEM with a register write");

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_stage #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                stall,
    input  wire                bubble,
    input  wire                branch_taken,
    input  wire rv_pkg::word_t branch_target,
    input  wire rv_pkg::word_t imem_data,
    output rv_pkg::word_t      imem_addr,
    output rv_pkg::ifid_t      ifid
);
    import rv_pkg::*;

    word_t pc;

    assign imem_addr = pc;

    // Redirect wins over a missing instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= reset_pc;
        end else if (!stall) begin
            if (branch_taken) pc <= branch_target;
            else if (!bubble) pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ifid.pc    <= '0;
            ifid.instr <= nop_instr;
        end else if (!stall) begin
            if (bubble || branch_taken) begin
                ifid.pc    <= '0;
                ifid.instr <= nop_instr; // Bubble
            end else begin
                ifid.pc    <= pc;
                ifid.instr <= imem_data;
            end
        end
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        imem_addr[1:0] == 2'b00)
        else $error("Fetch address %h not word aligned", imem_addr);

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module memory_stage (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 stall,
    input  wire rv_pkg::exmem_t exmem,
    output logic                dmem_write_enable,
    output rv_pkg::mem_width_e  dmem_width,
    output rv_pkg::word_t       dmem_addr,
    output rv_pkg::word_t       dmem_data,
    output rv_pkg::wb_t         wb
);

    // Data port straight from EX/MEM
    assign dmem_write_enable = exmem.mem_write;
    assign dmem_width        = exmem.mem_width;
    assign dmem_addr         = exmem.alu_out;
    assign dmem_data         = exmem.store_data;

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb <= '0;
        end else if (stall) begin
            wb.reg_write <= 1'b0; // Bubble while frozen
        end else begin
            wb.rd        <= exmem.rd;
            wb.reg_write <= exmem.reg_write;
            wb.data      <= exmem.alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`default_nettype none
`timescale 1ns/10ps

module register_file (
    input  wire                  clk,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    input  wire rv_pkg::wb_t     wb,
    output rv_pkg::word_t        rs1_data,
    output rv_pkg::word_t        rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 is not stored

    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write shows up on the read ports
    always_comb begin
        if (rs1 == '0)                                rs1_data = '0;
        else if (wb.reg_write && wb.rd == rs1)        rs1_data = wb.data;
        else                                          rs1_data = regs[rs1];

        if (rs2 == '0)                                rs2_data = '0;
        else if (wb.reg_write && wb.rd == rs2)        rs2_data = wb.data;
        else                                          rs2_data = regs[rs2];
    end

    a_x0_stays_zero: assert property (@(posedge clk)
        (wb.reg_write && wb.rd == '0) |=> (rs1 != '0 || rs1_data == '0))
        else $error("x0 read back non-zero after a write to x0");

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`default_nettype none
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                imem_ready,
    input  wire rv_pkg::word_t imem_data,
    output rv_pkg::word_t      imem_addr,
    input  wire                dmem_ready,
    output logic               dmem_write_enable,
    output rv_pkg::mem_width_e dmem_width,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::word_t      dmem_data
);
    import rv_pkg::*;

    ifid_t  ifid;
    idex_t  idex;
    exmem_t exmem;
    wb_t    wb;
    logic   branch_taken;
    word_t  branch_target;
    logic   stall_ex;
    logic   bubble_if;
    logic   flush_id;

    // ----------------------------------------
    // Hazard control
    // ----------------------------------------
    assign stall_ex  = !dmem_ready;  // Freezes everything up to EX/MEM
    assign bubble_if = !imem_ready;
    assign flush_id  = branch_taken; // Squash younger decode

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch_stage_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall         (stall_ex),
        .bubble        (bubble_if),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .ifid          (ifid)
    );

    decode_stage decode_stage_i (
        .clk     (clk),
        .reset_n (reset_n),
        .stall   (stall_ex),
        .flush   (flush_id),
        .ifid    (ifid),
        .wb      (wb),
        .idex    (idex)
    );

    execute_stage execute_stage_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall         (stall_ex),
        .idex          (idex),
        .wb            (wb),
        .exmem         (exmem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage memory_stage_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .stall             (stall_ex),
        .exmem             (exmem),
        .dmem_write_enable (dmem_write_enable),
        .dmem_width        (dmem_width),
        .dmem_addr         (dmem_addr),
        .dmem_data         (dmem_data),
        .wb                (wb)
    );

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    localparam word_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        br_none, br_beq, br_bne
    } branch_op_e;

    // One instruction word, four format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
    } instr_t;

    // ----------------------------------------
    // Pipeline register payloads
    // ----------------------------------------
    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } ifid_t;

    typedef struct packed {
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        word_t      rs1_data;
        word_t      rs2_data;
        alu_op_e    alu_op;
        logic       alu_src_imm;
        logic       reg_write;
        logic       mem_write;
        mem_width_e mem_width;
        branch_op_e branch_op;
    } idex_t;

    typedef struct packed {
        word_t      alu_out;
        word_t      store_data;
        reg_addr_t  rd;
        logic       reg_write;
        logic       mem_write;
        mem_width_e mem_width;
    } exmem_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      reg_write;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int max_instr   = 64;
    localparam int max_stores  = 32;
    localparam int max_targets = 16;
    localparam int max_cycles  = 40 * 50; // 40 instructions, worst stall and refill cost

    logic       clk;
    logic       reset_n;
    logic       imem_ready;
    logic       dmem_ready;
    word_t      imem_data;
    word_t      imem_addr;
    logic       dmem_write_enable;
    mem_width_e dmem_width;
    word_t      dmem_addr;
    word_t      dmem_data;
    logic       branch_taken;

    word_t       prog [0:max_instr-1];
    int          n_instr;
    word_t       exp_addr [0:max_stores-1];
    word_t       exp_data [0:max_stores-1];
    logic [1:0]  exp_width [0:max_stores-1];
    int          n_stores;
    word_t       exp_target [0:max_targets-1];
    int          n_targets;
    int          target_idx;
    int          store_idx;
    int          cycles;
    int          errors;
    logic        timed_out;
    logic [31:0] seed;

    // Previous-cycle copies for the hold and step checks
    logic       prev_valid;
    logic       prev_imem_ready;
    logic       prev_dmem_ready;
    logic       prev_taken;
    word_t      prev_target;
    word_t      prev_imem_addr;
    word_t      prev_dmem_addr;
    word_t      prev_dmem_data;
    logic [2:0] prev_dmem_ctrl;

    logic       store_fire;
    logic       store_known;
    word_t      want_addr;
    word_t      want_data;
    logic [1:0] want_width;
    word_t      want_target;

    tb_clock tb_clock_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    rv_core #(
        .reset_pc ('0)
    ) dut_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .imem_ready        (imem_ready),
        .imem_data         (imem_data),
        .imem_addr         (imem_addr),
        .dmem_ready        (dmem_ready),
        .dmem_write_enable (dmem_write_enable),
        .dmem_width        (dmem_width),
        .dmem_addr         (dmem_addr),
        .dmem_data         (dmem_data)
    );

    assign branch_taken = dut_i.branch_taken;

    // ----------------------------------------
    // Encoders and program
    // ----------------------------------------
    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc_op_imm};
    endfunction

    function automatic word_t s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
    endfunction

    task automatic emit(input word_t w);
        prog[n_instr] = w;
        n_instr++;
    endtask

    task automatic load_program();
        n_instr = 0;
        emit(i_type(5, 0, 0, 1));           // addi x1, x0, 5
        emit(i_type(-3, 1, 0, 2));          // addi x2, x1, -3   distance 1
        emit(r_type(0, 2, 1, 0, 3));        // add  x3, x1, x2   distance 1 and 2
        emit(r_type(32, 1, 3, 0, 4));       // sub  x4, x3, x1
        emit(s_type(256, 4, 0, 2));         // sw   x4, 0x100(x0)  data from previous
        emit(i_type(-1, 0, 0, 5));          // addi x5, x0, -1
        emit(i_type(28, 1, 1, 6));          // slli x6, x1, 28
        emit(s_type(260, 3, 0, 2));         // sw   x3, 0x104(x0)
        emit(r_type(0, 5, 1, 2, 7));        // slt  x7, x1, x5   5 < -1 signed
        emit(r_type(0, 5, 1, 3, 8));        // sltu x8, x1, x5
        emit(s_type(264, 7, 0, 2));         // sw   x7, 0x108(x0)
        emit(s_type(266, 8, 0, 1));         // sh   x8, 0x10a(x0)
        emit(i_type(12'h404, 5, 5, 9));     // srai x9, x5, 4
        emit(i_type(4, 5, 5, 10));          // srli x10, x5, 4
        emit(r_type(0, 10, 9, 4, 11));      // xor  x11, x9, x10
        emit(s_type(268, 11, 0, 2));        // sw   x11, 0x10c(x0)
        emit(r_type(32, 1, 11, 5, 12));     // sra  x12, x11, x1
        emit(r_type(0, 1, 11, 5, 13));      // srl  x13, x11, x1
        emit(r_type(0, 2, 6, 1, 14));       // sll  x14, x6, x2
        emit(s_type(272, 12, 0, 0));        // sb   x12, 0x110(x0)  distance 3
        emit(r_type(0, 14, 13, 6, 15));     // or   x15, x13, x14
        emit(r_type(0, 5, 12, 7, 16));      // and  x16, x12, x5
        emit(s_type(276, 15, 0, 2));        // sw   x15, 0x114(x0)
        emit(s_type(282, 16, 0, 1));        // sh   x16, 0x11a(x0)
        emit(i_type(0, 5, 2, 17));          // slti  x17, x5, 0
        emit(i_type(-1, 1, 3, 18));         // sltiu x18, x1, -1
        emit(r_type(0, 18, 17, 0, 19));     // add  x19, x17, x18
        emit(b_type(16, 2, 19, 0));         // beq  x19, x2, +16  taken
        emit(s_type(496, 1, 0, 2));         // Squashed path
        emit(s_type(500, 2, 0, 2));
        emit(s_type(504, 3, 0, 2));
        emit(b_type(8, 2, 19, 1));          // bne  x19, x2, +8   not taken
        emit(s_type(284, 19, 0, 2));        // sw   x19, 0x11c(x0)
        emit(r_type(0, 1, 5, 3, 20));       // sltu x20, x5, x1
        emit(b_type(12, 20, 1, 1));         // bne  x1, x20, +12  taken
        emit(s_type(480, 1, 0, 2));         // Squashed path
        emit(s_type(484, 1, 0, 0));
        emit(b_type(8, 1, 5, 4));           // blt  x5, x1  no-op in this core
        emit(b_type(8, 2, 1, 0));           // beq  x1, x2, +8   not taken
        emit(i_type(12'h7ff, 20, 0, 21));   // addi x21, x20, 0x7ff
        emit(s_type(288, 21, 0, 2));        // sw   x21, 0x120(x0)
        emit(b_type(0, 0, 0, 0));           // beq  x0, x0, 0  end loop
    endtask

    function automatic word_t fetch_word(word_t addr);
        if (addr < word_t'(n_instr * 4)) return prog[int'(addr >> 2)];
        return nop_instr; // Past the program
    endfunction

    // ----------------------------------------
    // Architectural reference model
    // ----------------------------------------
    function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_reference();
        word_t      xr [32];
        word_t      pc;
        word_t      next_pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm;
        logic [2:0] f3;
        logic       done;
        foreach (xr[i]) xr[i] = '0;
        pc        = '0;
        done      = 1'b0;
        n_stores  = 0;
        n_targets = 0;
        for (int step = 0; step < 200 && !done; step++) begin
            ins     = prog[int'(pc >> 2)];
            f3      = ins[14:12];
            a       = xr[ins[19:15]];
            b       = xr[ins[24:20]];
            next_pc = pc + 32'd4;
            case (ins[6:0])
                opc_op: xr[ins[11:7]] = ref_alu(f3, ins[30], a, b);
                opc_op_imm: begin
                    imm = {{20{ins[31]}}, ins[31:20]};
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {27'b0, ins[24:20]}; // Shift amount
                    xr[ins[11:7]] = ref_alu(f3, f3 == 3'd5 && ins[30], a, imm);
                end
                opc_store: begin
                    exp_addr[n_stores]  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_data[n_stores]  = b;
                    exp_width[n_stores] = f3[1:0];
                    n_stores++;
                end
                opc_branch: begin
                    imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                        done    = (imm == '0); // Branch to itself ends the program
                        next_pc = pc + imm;
                        exp_target[n_targets] = next_pc;
                        n_targets++;
                    end
                end
                default: ;
            endcase
            xr[0] = '0;
            pc    = next_pc;
        end
    endtask

    // ----------------------------------------
    // Stimulus and bookkeeping
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(negedge clk) begin
        seed = lcg_next(seed);
        imem_ready <= seed[31:30] != 2'b00; // Low about one cycle in four
        seed = lcg_next(seed);
        dmem_ready <= seed[31:30] != 2'b00;
        imem_data  <= fetch_word(imem_addr);
    end

    assign store_fire  = dmem_write_enable && dmem_ready;
    assign store_known = store_idx < n_stores;

    always_comb begin
        want_addr  = store_known ? exp_addr[store_idx] : '0;
        want_data  = store_known ? exp_data[store_idx] : '0;
        want_width = store_known ? exp_width[store_idx] : '0;
        if (target_idx < n_targets) want_target = exp_target[target_idx];
        else if (n_targets > 0)     want_target = exp_target[n_targets-1]; // End loop repeats
        else                        want_target = '0;
    end

    always @(posedge clk) begin
        prev_valid      <= reset_n;
        prev_imem_ready <= imem_ready;
        prev_dmem_ready <= dmem_ready;
        prev_taken      <= branch_taken;
        prev_target     <= want_target;
        prev_imem_addr  <= imem_addr;
        prev_dmem_addr  <= dmem_addr;
        prev_dmem_data  <= dmem_data;
        prev_dmem_ctrl  <= {dmem_write_enable, dmem_width};
        if (reset_n) cycles <= cycles + 1;
        if (reset_n && store_fire) store_idx <= store_idx + 1;
        if (reset_n && branch_taken && dmem_ready) target_idx <= target_idx + 1;
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        errors++;
        $display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_store_expected: assert property (@(posedge clk) disable iff (!reset_n)
        store_fire |-> store_known)
        else begin
            errors++;
            $display("Unexpected store to %h at %0t", $sampled(dmem_addr), $time);
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (store_fire && store_known) |-> dmem_addr == want_addr)
        else report_mismatch("dmem_addr", $sampled(dmem_addr), $sampled(want_addr));

    a_store_data: assert property (@(posedge clk) disable iff (!reset_n)
        (store_fire && store_known) |-> dmem_data == want_data)
        else report_mismatch("dmem_data", $sampled(dmem_data), $sampled(want_data));

    a_store_width: assert property (@(posedge clk) disable iff (!reset_n)
        (store_fire && store_known) |-> dmem_width == want_width)
        else report_mismatch("dmem_width", word_t'($sampled(dmem_width)),
                             word_t'($sampled(want_width)));

    a_reset_fetch: assert property (@(posedge clk) disable iff (!reset_n)
        !prev_valid |-> imem_addr == '0)
        else report_mismatch("imem_addr", $sampled(imem_addr), '0);

    a_reset_store: assert property (@(posedge clk) disable iff (!reset_n)
        !prev_valid |-> !dmem_write_enable)
        else report_mismatch("dmem_write_enable", word_t'($sampled(dmem_write_enable)), '0);

    // Fetch address holds, steps or redirects
    a_fetch_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && (!prev_dmem_ready || (!prev_imem_ready && !prev_taken)))
            |-> imem_addr == prev_imem_addr)
        else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(prev_imem_addr));

    a_fetch_step: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && prev_dmem_ready && prev_imem_ready && !prev_taken)
            |-> imem_addr == prev_imem_addr + 32'd4)
        else report_mismatch("imem_addr", $sampled(imem_addr),
                             $sampled(prev_imem_addr) + 32'd4);

    a_fetch_redirect: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && prev_dmem_ready && prev_taken) |-> imem_addr == prev_target)
        else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(prev_target));

    a_dmem_addr_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && !prev_dmem_ready) |-> dmem_addr == prev_dmem_addr)
        else report_mismatch("dmem_addr", $sampled(dmem_addr), $sampled(prev_dmem_addr));

    a_dmem_data_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && !prev_dmem_ready) |-> dmem_data == prev_dmem_data)
        else report_mismatch("dmem_data", $sampled(dmem_data), $sampled(prev_dmem_data));

    a_dmem_ctrl_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (prev_valid && !prev_dmem_ready) |-> {dmem_write_enable, dmem_width} == prev_dmem_ctrl)
        else report_mismatch("{dmem_write_enable, dmem_width}",
                             word_t'($sampled({dmem_write_enable, dmem_width})),
                             word_t'($sampled(prev_dmem_ctrl)));

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    initial begin
        imem_ready = 1'b1;
        dmem_ready = 1'b1;
        imem_data  = nop_instr;
        seed       = 32'd70847;
        cycles     = 0;
        errors     = 0;
        store_idx  = 0;
        target_idx = 0;
        timed_out  = 1'b0;
        load_program();
        run_reference();

        @(posedge reset_n);
        while (store_idx < n_stores && cycles < max_cycles) @(negedge clk);
        if (cycles >= max_cycles) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                     store_idx, n_stores, max_cycles);
        end else begin
            repeat (20) @(negedge clk); // Catch any late stray store
        end

        a_queue_empty: assert (store_idx == n_stores)
            else begin
                errors++;
                $display("Store queue not empty at the end: %0d of %0d stores seen",
                         store_idx, n_stores);
            end

        $display("Stores checked %0d of %0d, errors %0d", store_idx, n_stores, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
    parameter int half_period  = 2, // 4 ns clock
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/rv_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/alu.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
verif/tb_clock.sv
verif/rv_core_tb.sv
